//--- flist.f
logic/nf2_reg_pkg.sv
logic/reg_region_decode.sv
logic/reg_block_dispatch.sv
logic/device_id_regs.sv
logic/reg_resp_merge.sv
logic/nf2_reg_top.sv
testbench/tb_nf2_reg_top.sv

//--- logic/device_id_regs.sv
// Stage 3 of the register pipeline; read-only identification words with a registered ack
`timescale 1ns/1ps
`default_nettype none

module device_id_regs (
   input  wire                            core_clk_int,
   input  wire                            arst_n,
   input  wire                            id_req,
   input  wire                            id_rd_wr_n,
   input  wire nf2_reg_pkg::word_offset_t id_word,
   output logic                           id_ack,
   output nf2_reg_pkg::reg_data_t         id_rd_data
);

   import nf2_reg_pkg::*;

   reg_data_t rd_word;

   // -------------------------------------------------------------------
   // Word lookup
   // -------------------------------------------------------------------
   always_comb begin
      rd_word = '0;
      // Writes are acked but leave nothing behind
      if (id_rd_wr_n) begin
         case (id_word)
            ID_WORD_DEVICE_ID: rd_word = DEVICE_ID;
            ID_WORD_VERSION:   rd_word = DEVICE_VERSION;
            default:           rd_word = '0;
         endcase
      end
   end

   // -------------------------------------------------------------------
   // Registered response
   // -------------------------------------------------------------------
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         id_ack <= 1'b0;
      end else begin
         id_ack <= id_req;
      end
   end

   // Data is only looked at while id_ack is high
   always_ff @(posedge core_clk_int) begin
      if (id_req) begin
         id_rd_data <= rd_word;
      end else begin
         id_rd_data <= '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/nf2_reg_pkg.sv
// Shared widths, address fields, ID constants and types of the register path; import it
`default_nettype none

package nf2_reg_pkg;

   // -------------------------------------------------------------------
   // Register bus widths
   // -------------------------------------------------------------------
   localparam int REG_ADDR_WIDTH = 22;
   localparam int REG_DATA_WIDTH = 32;

   // Address split into region, block and word fields
   localparam int REGION_WIDTH = 2;
   localparam int BLOCK_WIDTH  = 4;
   localparam int WORD_WIDTH   = 16;
   localparam int BLOCK_LSB    = WORD_WIDTH;
   localparam int REGION_LSB   = WORD_WIDTH + BLOCK_WIDTH;

   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
   typedef logic [BLOCK_WIDTH-1:0]    block_idx_t;
   typedef logic [WORD_WIDTH-1:0]     word_offset_t;

   // Region 1 holds the sixteen 64k-word blocks
   localparam logic [REGION_WIDTH-1:0] CORE_REGION  = 2'd1;
   localparam block_idx_t              DEV_ID_BLOCK = 4'd0;

   // -------------------------------------------------------------------
   // Identification words
   // -------------------------------------------------------------------
   localparam word_offset_t ID_WORD_DEVICE_ID = 16'd0;
   localparam word_offset_t ID_WORD_VERSION   = 16'd1;

   localparam logic [7:0] DEVICE_MAJOR    = 8'd1;
   localparam logic [7:0] DEVICE_MINOR    = 8'd2;
   localparam logic [7:0] DEVICE_REVISION = 8'd3;

   localparam reg_data_t DEVICE_ID = 32'h0000_2001;
   // One byte per field, top byte left at zero
   localparam reg_data_t DEVICE_VERSION = {8'h00, DEVICE_MAJOR, DEVICE_MINOR,
                                           DEVICE_REVISION};

   // Read pattern for addresses with nothing behind them
   localparam reg_data_t UNUSED_RD_DATA = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- logic/nf2_reg_top.sv
// Top of the register access path; chains decode, dispatch, ID block and response merge
`timescale 1ns/1ps
`default_nettype none

module nf2_reg_top (
   input  wire                         core_clk_int,
   input  wire                         arst_n,
   input  wire                         reg_req,
   input  wire                         reg_rd_wr_n,
   input  wire nf2_reg_pkg::reg_addr_t reg_addr,
   input  wire nf2_reg_pkg::reg_data_t reg_wr_data,
   output logic                        reg_ack,
   output nf2_reg_pkg::reg_data_t      reg_rd_data
);

   import nf2_reg_pkg::*;

   // Stage 1 to stage 2
   logic         dec_req;
   logic         dec_rd_wr_n;
   logic         dec_in_core;
   block_idx_t   dec_block;
   word_offset_t dec_word;

   // Stage 2 to the targets
   logic         id_req;
   logic         id_rd_wr_n;
   word_offset_t id_word;
   logic         unused_req;
   logic         unused_rd_wr_n;

   // ID block response
   logic         id_ack;
   reg_data_t    id_rd_data;

   // -------------------------------------------------------------------
   // Address decode and dispatch
   // -------------------------------------------------------------------
   // No writable register downstream, so the write data stops here
   reg_region_decode reg_region_decode_inst (
      .core_clk_int (core_clk_int),
      .arst_n       (arst_n),
      .reg_req      (reg_req),
      .reg_rd_wr_n  (reg_rd_wr_n),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .dec_req      (dec_req),
      .dec_rd_wr_n  (dec_rd_wr_n),
      .dec_in_core  (dec_in_core),
      .dec_block    (dec_block),
      .dec_word     (dec_word),
      .dec_wr_data  ()
   );

   reg_block_dispatch reg_block_dispatch_inst (
      .core_clk_int   (core_clk_int),
      .arst_n         (arst_n),
      .dec_req        (dec_req),
      .dec_rd_wr_n    (dec_rd_wr_n),
      .dec_in_core    (dec_in_core),
      .dec_block      (dec_block),
      .dec_word       (dec_word),
      .id_req         (id_req),
      .id_rd_wr_n     (id_rd_wr_n),
      .id_word        (id_word),
      .unused_req     (unused_req),
      .unused_rd_wr_n (unused_rd_wr_n)
   );

   // -------------------------------------------------------------------
   // Targets and response
   // -------------------------------------------------------------------
   device_id_regs device_id_regs_inst (
      .core_clk_int (core_clk_int),
      .arst_n       (arst_n),
      .id_req       (id_req),
      .id_rd_wr_n   (id_rd_wr_n),
      .id_word      (id_word),
      .id_ack       (id_ack),
      .id_rd_data   (id_rd_data)
   );

   reg_resp_merge reg_resp_merge_inst (
      .core_clk_int   (core_clk_int),
      .arst_n         (arst_n),
      .unused_req     (unused_req),
      .unused_rd_wr_n (unused_rd_wr_n),
      .id_ack         (id_ack),
      .id_rd_data     (id_rd_data),
      .reg_ack        (reg_ack),
      .reg_rd_data    (reg_rd_data)
   );

endmodule

`default_nettype wire

//--- logic/reg_block_dispatch.sv
// Stage 2 of the register pipeline; steers each request to the ID block or unused space
`timescale 1ns/1ps
`default_nettype none

module reg_block_dispatch (
   input  wire                            core_clk_int,
   input  wire                            arst_n,
   input  wire                            dec_req,
   input  wire                            dec_rd_wr_n,
   input  wire                            dec_in_core,
   input  wire nf2_reg_pkg::block_idx_t   dec_block,
   input  wire nf2_reg_pkg::word_offset_t dec_word,
   output logic                           id_req,
   output logic                           id_rd_wr_n,
   output nf2_reg_pkg::word_offset_t      id_word,
   output logic                           unused_req,
   output logic                           unused_rd_wr_n
);

   import nf2_reg_pkg::*;

   logic id_hit;

   // -------------------------------------------------------------------
   // Block select inside the core region
   // -------------------------------------------------------------------
   always_comb begin
      id_hit = dec_in_core && (dec_block == DEV_ID_BLOCK);
   end

   // One of the two strobes fires for every request
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         id_req         <= 1'b0;
         id_rd_wr_n     <= 1'b0;
         unused_req     <= 1'b0;
         unused_rd_wr_n <= 1'b0;
      end else begin
         id_req         <= dec_req && id_hit;
         id_rd_wr_n     <= dec_rd_wr_n;
         unused_req     <= dec_req && !id_hit;
         unused_rd_wr_n <= dec_rd_wr_n;
      end
   end

   // Word offset only matters to the ID block
   always_ff @(posedge core_clk_int) begin
      id_word <= dec_word;
   end

endmodule

`default_nettype wire

//--- logic/reg_region_decode.sv
// Stage 1 of the register pipeline; registers a host request and splits its address
`timescale 1ns/1ps
`default_nettype none

module reg_region_decode (
   input  wire                         core_clk_int,
   input  wire                         arst_n,
   input  wire                         reg_req,
   input  wire                         reg_rd_wr_n,
   input  wire nf2_reg_pkg::reg_addr_t reg_addr,
   input  wire nf2_reg_pkg::reg_data_t reg_wr_data,
   output logic                        dec_req,
   output logic                        dec_rd_wr_n,
   output logic                        dec_in_core,
   output nf2_reg_pkg::block_idx_t     dec_block,
   output nf2_reg_pkg::word_offset_t   dec_word,
   output nf2_reg_pkg::reg_data_t      dec_wr_data
);

   import nf2_reg_pkg::*;

   // -------------------------------------------------------------------
   // Request strobe and region match
   // -------------------------------------------------------------------
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         dec_req     <= 1'b0;
         dec_rd_wr_n <= 1'b0;
         dec_in_core <= 1'b0;
      end else begin
         // Accepted every cycle the strobe is high
         dec_req     <= reg_req;
         dec_rd_wr_n <= reg_rd_wr_n;
         dec_in_core <= (reg_addr[REGION_LSB +: REGION_WIDTH] == CORE_REGION);
      end
   end

   // Address fields and write data
   always_ff @(posedge core_clk_int) begin
      dec_block   <= reg_addr[BLOCK_LSB +: BLOCK_WIDTH];
      dec_word    <= reg_addr[WORD_WIDTH-1:0];
      dec_wr_data <= reg_wr_data;
   end

endmodule

`default_nettype wire

//--- logic/reg_resp_merge.sv
// Stages 3 and 4 of the register pipeline; answers unused space and merges both responses
`timescale 1ns/1ps
`default_nettype none

module reg_resp_merge (
   input  wire                         core_clk_int,
   input  wire                         arst_n,
   input  wire                         unused_req,
   input  wire                         unused_rd_wr_n,
   input  wire                         id_ack,
   input  wire nf2_reg_pkg::reg_data_t id_rd_data,
   output logic                        reg_ack,
   output nf2_reg_pkg::reg_data_t      reg_rd_data
);

   import nf2_reg_pkg::*;

   logic      unused_ack;
   reg_data_t unused_rd_data;

   // -------------------------------------------------------------------
   // Unused space responder
   // -------------------------------------------------------------------
   // Extra register so it lines up with the ID block's ack
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         unused_ack <= 1'b0;
      end else begin
         unused_ack <= unused_req;
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (unused_req && unused_rd_wr_n) begin
         unused_rd_data <= UNUSED_RD_DATA;
      end else begin
         unused_rd_data <= '0;
      end
   end

   // -------------------------------------------------------------------
   // Response merge
   // -------------------------------------------------------------------
   // Only one source acks in any cycle
   always_ff @(posedge core_clk_int or negedge arst_n) begin
      if (!arst_n) begin
         reg_ack     <= 1'b0;
         reg_rd_data <= '0;
      end else begin
         reg_ack <= id_ack || unused_ack;
         if (id_ack) begin
            reg_rd_data <= id_rd_data;
         end else if (unused_ack) begin
            reg_rd_data <= unused_rd_data;
         end else begin
            reg_rd_data <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_nf2_reg_top \
   -f flist.f -o sim_nf2_reg > build.log 2>&1 \
   && ./obj_dir/sim_nf2_reg > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && exit 0 || exit 1

//--- testbench/tb_nf2_reg_top.sv
// Testbench for the register access path; directed and seeded random requests vs a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_nf2_reg_top;

   import nf2_reg_pkg::*;

   localparam int CLK_PERIOD    = 100;
   localparam int RESET_CYCLES  = 5;
   localparam int RANDOM_REQS   = 300;
   localparam int DIRECTED_REQS = 49;
   localparam int DRAIN_LIMIT   = 10;
   // Random traffic idles about 30 percent of cycles, so two cycles per request is plenty
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 10 + 2 * (RANDOM_REQS + DIRECTED_REQS)
                                   + 5 * (DRAIN_LIMIT + 3) + 20;

   logic      core_clk_int;
   logic      arst_n;
   logic      reg_req;
   logic      reg_rd_wr_n;
   reg_addr_t reg_addr;
   reg_data_t reg_wr_data;
   logic      reg_ack;
   reg_data_t reg_rd_data;

   integer    seed = 38;
   int        cycle_cnt = 0;
   int        error_cnt = 0;
   int        errors_at_start = 0;
   int        pass_cnt = 0;
   int        fail_cnt = 0;
   string     cur_test = "reset";
   reg_data_t exp_data_q[$];
   int        exp_due_q[$];

   nf2_reg_top nf2_reg_top_inst (
      .core_clk_int (core_clk_int),
      .arst_n       (arst_n),
      .reg_req      (reg_req),
      .reg_rd_wr_n  (reg_rd_wr_n),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .reg_ack      (reg_ack),
      .reg_rd_data  (reg_rd_data)
   );

   initial begin
      core_clk_int = 1'b0;
      forever #(CLK_PERIOD / 2) core_clk_int = ~core_clk_int;
   end

   always @(posedge core_clk_int) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // -------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------
   // Top two bits pick the region, the next four the block
   function automatic reg_data_t expected_rd_data(input logic rd, input reg_addr_t addr);
      logic [REGION_WIDTH-1:0] region;
      block_idx_t              block;
      word_offset_t            word;
      region = addr[REG_ADDR_WIDTH-1 -: REGION_WIDTH];
      block  = addr[WORD_WIDTH +: BLOCK_WIDTH];
      word   = addr[WORD_WIDTH-1:0];
      if (!rd) return '0;
      if (region != CORE_REGION || block != DEV_ID_BLOCK) return 32'hDEAD_BEEF;
      if (word == 16'd0) return 32'h0000_2001;
      // Major 1, minor 2, revision 3 under a zero top byte
      if (word == 16'd1) return {8'h00, 8'd1, 8'd2, 8'd3};
      return '0;
   endfunction

   function automatic reg_addr_t make_addr(input logic [REGION_WIDTH-1:0] region,
                                           input block_idx_t block, input word_offset_t word);
      return {region, block, word};
   endfunction

   // -------------------------------------------------------------------
   // Stimulus and scoring
   // -------------------------------------------------------------------
   task automatic issue_request(input logic rd, input reg_addr_t addr, input reg_data_t data);
      @(posedge core_clk_int);
      reg_req     <= 1'b1;
      reg_rd_wr_n <= rd;
      reg_addr    <= addr;
      reg_wr_data <= data;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge core_clk_int);
         reg_req <= 1'b0;
      end
   endtask

   task automatic start_test(input string name);
      cur_test        = name;
      errors_at_start = error_cnt;
   endtask

   // Pipeline empties, then the test is scored
   task automatic finish_test;
      int waited;
      waited = 0;
      idle_cycles(1);
      while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge core_clk_int);
         waited++;
      end
      idle_cycles(2);
      if (error_cnt == errors_at_start) begin
         $display("test %s passed", cur_test);
         pass_cnt++;
      end else begin
         $display("test %s failed with %0d errors", cur_test, error_cnt - errors_at_start);
         fail_cnt++;
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge core_clk_int) begin : check_response
      reg_data_t exp_data;
      int        exp_due;
      if (reg_ack === 1'b1) begin
         if (exp_data_q.size() == 0) begin
            $display("%s: ack arrived with no request pending", cur_test);
            error_cnt++;
         end else begin
            exp_data = exp_data_q.pop_front();
            exp_due  = exp_due_q.pop_front();
            if (exp_due != cycle_cnt) begin
               $display("error %s: ack cycle expected %0d actual %0d", cur_test, exp_due,
                        cycle_cnt);
               error_cnt++;
            end
            if (reg_rd_data !== exp_data) begin
               $display("error %s: expected %h actual %h", cur_test, exp_data, reg_rd_data);
               error_cnt++;
            end
         end
      end else if (reg_rd_data !== '0) begin
         $display("error %s: idle data expected %h actual %h", cur_test, 32'h0, reg_rd_data);
         error_cnt++;
      end else if (exp_due_q.size() != 0 && exp_due_q[0] < cycle_cnt) begin
         $display("%s: no ack for the request due at cycle %0d", cur_test, exp_due_q[0]);
         void'(exp_data_q.pop_front());
         void'(exp_due_q.pop_front());
         error_cnt++;
      end
      // Sampled by the DUT at the next rising edge, acked four edges later
      if (reg_req === 1'b1) begin
         exp_data_q.push_back(expected_rd_data(reg_rd_wr_n, reg_addr));
         exp_due_q.push_back(cycle_cnt + 4);
      end
   end

   initial begin : watchdog
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("watchdog: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // -------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------
   initial begin : main_sequence
      logic [31:0] rnd;
      logic [31:0] pick;
      int          issued;
      reg_req     <= 1'b0;
      reg_rd_wr_n <= 1'b0;
      reg_addr    <= '0;
      reg_wr_data <= '0;
      arst_n      <= 1'b0;
      repeat (RESET_CYCLES) @(posedge core_clk_int);
      arst_n <= 1'b1;

      // Monitor flags any ack or data while idle
      start_test("reset_idle");
      idle_cycles(10);
      finish_test();

      start_test("id_block_reads");
      for (int w = 0; w < 6; w++) begin
         issue_request(1'b1, make_addr(CORE_REGION, DEV_ID_BLOCK, word_offset_t'(w)), '0);
      end
      issue_request(1'b1, make_addr(CORE_REGION, DEV_ID_BLOCK, 16'hFFFF), '0);
      idle_cycles(3);
      issue_request(1'b1, make_addr(CORE_REGION, DEV_ID_BLOCK, 16'd1), '0);
      finish_test();

      start_test("unused_space");
      for (int r = 0; r < 4; r++) begin
         for (int i = 0; i < 4 && r != 1; i++) begin
            rnd = $random(seed);
            // First two sit where the ID words are in the core region
            if (i < 2) begin
               issue_request(1'b1, make_addr(2'(r), DEV_ID_BLOCK, word_offset_t'(i)), '0);
            end else begin
               issue_request(1'b1, make_addr(2'(r), rnd[19:16], rnd[15:0]), '0);
            end
         end
      end
      for (int b = 1; b < 16; b++) begin
         rnd = $random(seed);
         issue_request(1'b1, make_addr(CORE_REGION, block_idx_t'(b), rnd[15:0]), '0);
      end
      repeat (8) begin
         rnd  = $random(seed);
         pick = $random(seed);
         issue_request(1'b0, rnd[21:0], pick);
      end
      finish_test();

      start_test("id_write_then_read");
      for (int w = 0; w < 3; w++) begin
         pick = $random(seed);
         issue_request(1'b0, make_addr(CORE_REGION, DEV_ID_BLOCK, word_offset_t'(w)), pick);
         issue_request(1'b1, make_addr(CORE_REGION, DEV_ID_BLOCK, word_offset_t'(w)), '0);
      end
      finish_test();

      start_test("random_traffic");
      issued = 0;
      while (issued < RANDOM_REQS) begin
         rnd = $random(seed);
         if (rnd % 10 >= 7) begin
            idle_cycles(1);
         end else begin
            pick = $random(seed);
            // Every fourth request aims at the low ID words
            if (pick[1:0] == 2'b00) begin
               issue_request(pick[4], make_addr(CORE_REGION, DEV_ID_BLOCK,
                                                word_offset_t'(pick[3:2])), rnd);
            end else begin
               issue_request(pick[4], pick[31:10], rnd);
            end
            issued++;
         end
      end
      finish_test();

      $display("tests %0d passed %0d failed %0d errors %0d", pass_cnt + fail_cnt, pass_cnt,
               fail_cnt, error_cnt);
      if (fail_cnt == 0 && error_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
